// File: verilog.f
+incdir+.
rdma_sq_pkg.sv
wqe_decoder.sv
segment_engine.sv
completion_tracker.sv
rdma_sq_top.sv
rdma_sq_props.sv
tb_rdma_sq_checker.sv
tb_rdma_sq.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      := tb_rdma_sq
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_rdma_sq.sv
`include "rdma_sq_defs.svh"

module tb_rdma_sq;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          N_GROUPS    = 6;
  localparam int          PER_GROUP   = 8;
  localparam int          N_TESTS     = N_GROUPS * PER_GROUP;
  localparam int          CLK_NS      = 10;
  localparam int          MAX_SEG     = 16;
  // up to two nacks that each throw away a full count
  localparam int          MAX_RSP     = 3 * MAX_SEG;
  localparam int          WATCHDOG_NS = N_TESTS * (MAX_SEG + MAX_RSP) * 20 * CLK_NS;
  localparam logic [31:0] SEED        = 32'd98497;

  logic                   axis_aclk;
  logic                   axis_rstn;
  logic                   wqe_valid;
  rdma_sq_pkg::wqe_word_t wqe;
  rdma_sq_pkg::qpn_t      qpn;
  rdma_sq_pkg::vaddr_t    lvaddr;
  rdma_sq_pkg::mtu_code_t mtu_code;
  logic                   wqe_ready;
  rdma_sq_pkg::sq_req_t   req;
  logic                   req_valid;
  logic                   req_ready;
  logic                   rx_ack;
  logic                   rx_nack;
  logic                   rx_dat;
  rdma_sq_pkg::cqe_t      cqe;
  logic                   cqe_valid;
  rdma_sq_pkg::cq_idx_t   cq_idx;
  logic [2:0]             grp;
  logic                   nack_en;
  int                     err_cnt;
  int                     done_cnt;
  int                     req_left;

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  rdma_sq_top u_dut (
    .axis_aclk_i     (axis_aclk),
    .axis_rstn_i     (axis_rstn),
    .wqe_valid_i     (wqe_valid),
    .wqe_i           (wqe),
    .qpn_i           (qpn),
    .local_vaddr_i   (lvaddr),
    .mtu_code_i      (mtu_code),
    .wqe_ready_o     (wqe_ready),
    .req_o           (req),
    .req_valid_o     (req_valid),
    .req_ready_i     (req_ready),
    .rx_ack_valid_i  (rx_ack),
    .rx_nack_valid_i (rx_nack),
    .rx_dat_valid_i  (rx_dat),
    .cqe_o           (cqe),
    .cqe_valid_o     (cqe_valid),
    .cq_idx_o        (cq_idx)
  );

  tb_rdma_sq_checker u_chk (
    .axis_aclk_i     (axis_aclk),
    .axis_rstn_i     (axis_rstn),
    .group_i         (grp),
    .wqe_valid_i     (wqe_valid),
    .wqe_ready_i     (wqe_ready),
    .wqe_i           (wqe),
    .qpn_i           (qpn),
    .local_vaddr_i   (lvaddr),
    .mtu_code_i      (mtu_code),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_i     (req_ready),
    .rx_ack_valid_i  (rx_ack),
    .rx_nack_valid_i (rx_nack),
    .rx_dat_valid_i  (rx_dat),
    .cqe_i           (cqe),
    .cqe_valid_i     (cqe_valid),
    .cq_idx_i        (cq_idx),
    .err_cnt_o       (err_cnt),
    .done_cnt_o      (done_cnt),
    .req_left_o      (req_left)
  );

  bind segment_engine rdma_sq_props u_seg_props (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .req_valid_i (req_valid_o),
    .req_ready_i (req_ready_i),
    .req_i       (req_o),
    .idle_i      (idle_i),
    .cqe_valid_i (1'b0)
  );

  bind completion_tracker rdma_sq_props u_trk_props (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .req_valid_i (1'b0),
    .req_ready_i (1'b1),
    .req_i       ('0),
    .idle_i      (1'b1),
    .cqe_valid_i (cqe_valid_o)
  );

  initial begin
    axis_aclk = 1'b0;
    forever #(CLK_NS / 2) axis_aclk = ~axis_aclk;
  end

  //////////////////////////////////////////////////
  // wqe stimulus

  initial begin : drive_wqe
    logic [31:0] rs;
    logic [31:0] len;
    logic [7:0]  opc;
    logic [2:0]  code;
    rs        = SEED;
    axis_rstn = 1'b0;
    wqe_valid = 1'b0;
    wqe       = '0;
    qpn       = '0;
    lvaddr    = '0;
    mtu_code  = '0;
    grp       = '0;
    nack_en   = 1'b0;
    repeat (3) @(posedge axis_aclk);
    @(negedge axis_aclk);
    axis_rstn = 1'b1;
    for (int g = 0; g < N_GROUPS; g++) begin
      for (int i = 0; i < PER_GROUP; i++) begin
        while (!wqe_ready) @(negedge axis_aclk);
        for (int j = 0; j < 8; j++) begin
          rs = next_rand(rs);
          wqe[j*32 +: 32] = rs;
        end
        rs   = next_rand(rs);
        code = 3'(rs % 5);
        // a quarter of the lengths are whole multiples of 256
        len  = (rs[4:3] == 2'b00) ? ((32'(rs[8:5]) + 32'd1) << 8) : (32'(rs[20:9]) + 32'd1);
        case (g)
          0: opc = 8'h00;
          1: opc = 8'h02;
          2: opc = 8'h04;
          default: opc = 8'(2 * (rs[23:21] % 3));
        endcase
        if (g == 4) begin
          rs = next_rand(rs);
          case (rs[1:0])
            2'd0: begin
              opc = rs[15:8];
              if (opc inside {8'h00, 8'h02, 8'h04}) begin
                opc = opc | 8'h01;
              end
            end
            2'd1: len = '0;
            default: code = 3'd5 + 3'(rs[3:2] % 3);
          endcase
        end
        wqe[`RDMA_OPC_LSB +: 8]  = opc;
        wqe[`RDMA_LEN_LSB +: 32] = len;
        mtu_code = code;
        rs       = next_rand(rs);
        qpn      = rs[23:0];
        rs       = next_rand(rs);
        lvaddr   = {rs, next_rand(rs)};
        rs       = next_rand(next_rand(rs));
        grp      = 3'(g);
        nack_en  = (g >= 3);
        wqe_valid = 1'b1;
        @(negedge axis_aclk);
        wqe_valid = 1'b0;
        // last group runs back to back
        if (g < N_GROUPS - 1) begin
          repeat (int'(rs[31:30])) @(negedge axis_aclk);
        end
      end
    end
    wait (done_cnt == N_TESTS);
    repeat (10) @(negedge axis_aclk);
    $display("%0d tests, %0d errors, %0d requests never seen", done_cnt, err_cnt, req_left);
    if (err_cnt == 0 && req_left == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : drive_ready
    logic [31:0] rs;
    rs        = next_rand(SEED);
    req_ready = 1'b0;
    forever begin
      @(negedge axis_aclk);
      rs        = next_rand(rs);
      req_ready = (grp == 3'(N_GROUPS - 1)) ? rs[0] : 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // responses sent only while the tracker counts

  initial begin : respond
    logic [31:0] rs;
    logic        is_read;
    logic        hit;
    int          nacks;
    rs      = next_rand(next_rand(SEED));
    rx_ack  = 1'b0;
    rx_nack = 1'b0;
    rx_dat  = 1'b0;
    forever begin
      @(posedge axis_aclk);
      if (req_valid && req_ready && req.last) begin
        is_read = (req.opcode == rdma_sq_pkg::READ_REQUEST);
        nacks   = 0;
        // hand-over reaches the tracker on the next edge
        @(posedge axis_aclk);
        @(negedge axis_aclk);
        while (!cqe_valid) begin
          rs      = next_rand(rs);
          hit     = (rs[2:0] != 3'd0);
          rx_nack = nack_en && (nacks < 2) && (rs[7:4] == 4'd0);
          // strobes of the other kind must be ignored
          rx_ack  = is_read ? (rs[9:8] == 2'b11) : hit;
          rx_dat  = is_read ? hit : (rs[9:8] == 2'b11);
          if (rx_nack) begin
            nacks++;
          end
          @(negedge axis_aclk);
        end
        rx_ack  = 1'b0;
        rx_nack = 1'b0;
        rx_dat  = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, %0d of %0d tests completed", WATCHDOG_NS, done_cnt,
             N_TESTS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb_rdma_sq_checker.sv
`include "rdma_sq_defs.svh"

module tb_rdma_sq_checker (
  input  logic                   axis_aclk_i,
  input  logic                   axis_rstn_i,
  input  logic [2:0]             group_i,
  input  logic                   wqe_valid_i,
  input  logic                   wqe_ready_i,
  input  rdma_sq_pkg::wqe_word_t wqe_i,
  input  rdma_sq_pkg::qpn_t      qpn_i,
  input  rdma_sq_pkg::vaddr_t    local_vaddr_i,
  input  rdma_sq_pkg::mtu_code_t mtu_code_i,
  input  rdma_sq_pkg::sq_req_t   req_i,
  input  logic                   req_valid_i,
  input  logic                   req_ready_i,
  input  logic                   rx_ack_valid_i,
  input  logic                   rx_nack_valid_i,
  input  logic                   rx_dat_valid_i,
  input  rdma_sq_pkg::cqe_t      cqe_i,
  input  logic                   cqe_valid_i,
  input  rdma_sq_pkg::cq_idx_t   cq_idx_i,
  output int                     err_cnt_o,
  output int                     done_cnt_o,
  output int                     req_left_o
);
  timeunit 1ns;
  timeprecision 1ps;

  rdma_sq_pkg::sq_req_t exp_req_q[$];
  string                req_name_q[$];
  rdma_sq_pkg::cqe_t    exp_cqe_q[$];
  int                   exp_cnt_q[$];
  logic                 dat_q[$];
  string                cqe_name_q[$];
  int                   err_cnt  = 0;
  int                   done_cnt = 0;
  int                   err_mark = 0;
  int                   seq      = 0;
  int                   rsp_cnt  = 0;

  function automatic string group_name(input logic [2:0] g);
    case (g)
      3'd0: return "write";
      3'd1: return "send";
      3'd2: return "read";
      3'd3: return "nack";
      3'd4: return "bad_wqe";
      default: return "backpressure";
    endcase
  endfunction

  // expected requests and completion of one wqe
  function automatic void predict(
    input rdma_sq_pkg::wqe_word_t w,
    input rdma_sq_pkg::qpn_t      qpn,
    input rdma_sq_pkg::vaddr_t    lv,
    input rdma_sq_pkg::mtu_code_t code,
    input string                  name
  );
    logic [7:0]           opc;
    logic [63:0]          len;
    logic [63:0]          mtu;
    logic [63:0]          n;
    logic                 bad;
    logic                 is_send;
    rdma_sq_pkg::vaddr_t  rv;
    rdma_sq_pkg::sq_req_t r;
    rdma_sq_pkg::cqe_t    c;
    opc     = w[`RDMA_OPC_LSB +: 8];
    len     = 64'(w[`RDMA_LEN_LSB +: 32]);
    rv      = w[`RDMA_RVADDR_LSB +: 64];
    mtu     = 64'd1 << (`RDMA_MTU_BASE_LOG + int'(code));
    bad     = !(opc inside {8'h00, 8'h02, 8'h04}) || (len == 0) ||
              (code > `RDMA_MTU_CODE_MAX);
    is_send = (opc == 8'h02);
    n       = bad ? 64'd0 : (len + mtu - 1) / mtu;
    c.wr_id  = w[`RDMA_WRID_LSB +: 16];
    c.opcode = opc;
    c.status = bad ? 8'(`RDMA_STATUS_BAD_WQE) : 8'(`RDMA_STATUS_OK);
    r.qpn    = qpn;
    if (!bad && opc == 8'h04) begin
      r.opcode = rdma_sq_pkg::READ_REQUEST;
      r.last   = 1'b1;
      r.lvaddr = lv;
      r.rvaddr = rv;
      r.len    = 32'(len);
      exp_req_q.push_back(r);
      req_name_q.push_back(name);
    end else begin
      for (int i = 0; i < int'(n); i++) begin
        r.last   = (64'(i) == n - 1);
        r.len    = r.last ? 32'(len - 64'(i) * mtu) : 32'(mtu);
        r.lvaddr = lv + 64'(i) * mtu;
        r.rvaddr = is_send ? r.lvaddr : rv + 64'(i) * mtu;
        if (n == 1) begin
          r.opcode = is_send ? rdma_sq_pkg::SEND_ONLY : rdma_sq_pkg::WRITE_ONLY;
        end else if (i == 0) begin
          r.opcode = is_send ? rdma_sq_pkg::SEND_FIRST : rdma_sq_pkg::WRITE_FIRST;
        end else if (r.last) begin
          r.opcode = is_send ? rdma_sq_pkg::SEND_LAST : rdma_sq_pkg::WRITE_LAST;
        end else begin
          r.opcode = is_send ? rdma_sq_pkg::SEND_MIDDLE : rdma_sq_pkg::WRITE_MIDDLE;
        end
        exp_req_q.push_back(r);
        req_name_q.push_back(name);
      end
    end
    exp_cqe_q.push_back(c);
    exp_cnt_q.push_back(int'(n));
    dat_q.push_back(!bad && opc == 8'h04);
    cqe_name_q.push_back(name);
  endfunction

  initial begin
    @(posedge axis_rstn_i);
    if (req_valid_i !== 1'b0 || cqe_valid_i !== 1'b0 || wqe_ready_i !== 1'b1 ||
        cq_idx_i !== '0) begin
      $display("outputs are not at their reset values when reset ends");
      err_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // compare

  always @(posedge axis_aclk_i) begin : compare
    rdma_sq_pkg::sq_req_t e;
    rdma_sq_pkg::cqe_t    c;
    string                name;
    int                   n;
    logic                 cnt_dat;
    if (axis_rstn_i) begin
      if (wqe_valid_i && wqe_ready_i) begin
        predict(wqe_i, qpn_i, local_vaddr_i, mtu_code_i,
                $sformatf("%s_%0d", group_name(group_i), seq));
        seq++;
      end
      if (req_valid_i && req_ready_i) begin
        if (exp_req_q.size() == 0) begin
          $display("a request was sent that no work request asked for: %h", req_i);
          err_cnt++;
        end else begin
          e    = exp_req_q.pop_front();
          name = req_name_q.pop_front();
          if (req_i !== e) begin
            $display("FAILED %s request expected %h actual %h", name, e, req_i);
            err_cnt++;
          end
        end
      end
      if (cqe_valid_i) begin
        if (exp_cqe_q.size() == 0) begin
          $display("a completion arrived with no work request outstanding");
          err_cnt++;
        end else begin
          c       = exp_cqe_q.pop_front();
          n       = exp_cnt_q.pop_front();
          cnt_dat = dat_q.pop_front();
          name    = cqe_name_q.pop_front();
          if (cqe_i !== c) begin
            $display("FAILED %s completion expected %h actual %h", name, c, cqe_i);
            err_cnt++;
          end
          if (rsp_cnt != n) begin
            $display("FAILED %s responses (data %0b) expected %0d actual %0d", name,
                     cnt_dat, n, rsp_cnt);
            err_cnt++;
          end
          if (cq_idx_i !== 32'(done_cnt + 1)) begin
            $display("FAILED %s cq index expected %0d actual %0d", name, done_cnt + 1,
                     cq_idx_i);
            err_cnt++;
          end
          done_cnt++;
          $display("%s: %s", name, (err_cnt == err_mark) ? "ok" : "mismatch");
          err_mark = err_cnt;
        end
        rsp_cnt = 0;
      end
      // nack wins over a response in the same cycle
      if (rx_nack_valid_i) begin
        rsp_cnt = 0;
      end else if (dat_q.size() != 0 && (dat_q[0] ? rx_dat_valid_i : rx_ack_valid_i)) begin
        rsp_cnt++;
      end
    end
  end

  assign err_cnt_o  = err_cnt;
  assign done_cnt_o = done_cnt;
  assign req_left_o = exp_req_q.size();

endmodule

// File: rdma_sq_props.sv
module rdma_sq_props (
  input logic                 axis_aclk_i,
  input logic                 axis_rstn_i,
  input logic                 req_valid_i,
  input logic                 req_ready_i,
  input rdma_sq_pkg::sq_req_t req_i,
  input logic                 idle_i,
  input logic                 cqe_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // request held until the transfer
  req_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else $error("request changed or dropped while stalled");

  // only one work request counted at a time
  req_when_idle: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    req_valid_i |-> idle_i)
    else $error("request issued while the tracker counts another work request");

  cqe_pulse: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    cqe_valid_i |=> !cqe_valid_i)
    else $error("completion valid held for more than one cycle");

endmodule

// File: rdma_sq_top.sv
module rdma_sq_top (
  input  logic                   axis_aclk_i,
  input  logic                   axis_rstn_i,
  input  logic                   wqe_valid_i,
  input  rdma_sq_pkg::wqe_word_t wqe_i,
  input  rdma_sq_pkg::qpn_t      qpn_i,
  input  rdma_sq_pkg::vaddr_t    local_vaddr_i,
  input  rdma_sq_pkg::mtu_code_t mtu_code_i,
  output logic                   wqe_ready_o,
  output rdma_sq_pkg::sq_req_t   req_o,
  output logic                   req_valid_o,
  input  logic                   req_ready_i,
  input  logic                   rx_ack_valid_i,
  input  logic                   rx_nack_valid_i,
  input  logic                   rx_dat_valid_i,
  output rdma_sq_pkg::cqe_t      cqe_o,
  output logic                   cqe_valid_o,
  output rdma_sq_pkg::cq_idx_t   cq_idx_o
);

  rdma_sq_pkg::wqe_cmd_t cmd;
  logic                  cmd_valid;
  logic                  cmd_take;
  rdma_sq_pkg::done_t    done;
  logic                  done_valid;
  logic                  idle;

  //////////////////////////////////////////////////
  // decode, execute, result

  wqe_decoder u_decode (
    .axis_aclk_i   (axis_aclk_i),
    .axis_rstn_i   (axis_rstn_i),
    .wqe_valid_i   (wqe_valid_i),
    .wqe_i         (wqe_i),
    .qpn_i         (qpn_i),
    .local_vaddr_i (local_vaddr_i),
    .mtu_code_i    (mtu_code_i),
    .wqe_ready_o   (wqe_ready_o),
    .cmd_take_i    (cmd_take),
    .cmd_o         (cmd),
    .cmd_valid_o   (cmd_valid)
  );

  segment_engine u_execute (
    .axis_aclk_i  (axis_aclk_i),
    .axis_rstn_i  (axis_rstn_i),
    .cmd_i        (cmd),
    .cmd_valid_i  (cmd_valid),
    .cmd_take_o   (cmd_take),
    .idle_i       (idle),
    .req_o        (req_o),
    .req_valid_o  (req_valid_o),
    .req_ready_i  (req_ready_i),
    .done_o       (done),
    .done_valid_o (done_valid)
  );

  completion_tracker u_result (
    .axis_aclk_i     (axis_aclk_i),
    .axis_rstn_i     (axis_rstn_i),
    .done_i          (done),
    .done_valid_i    (done_valid),
    .idle_o          (idle),
    .rx_ack_valid_i  (rx_ack_valid_i),
    .rx_nack_valid_i (rx_nack_valid_i),
    .rx_dat_valid_i  (rx_dat_valid_i),
    .cqe_o           (cqe_o),
    .cqe_valid_o     (cqe_valid_o),
    .cq_idx_o        (cq_idx_o)
  );

endmodule

// File: completion_tracker.sv
module completion_tracker (
  input  logic                 axis_aclk_i,
  input  logic                 axis_rstn_i,
  input  rdma_sq_pkg::done_t   done_i,
  input  logic                 done_valid_i,
  output logic                 idle_o,
  input  logic                 rx_ack_valid_i,
  input  logic                 rx_nack_valid_i,
  input  logic                 rx_dat_valid_i,
  output rdma_sq_pkg::cqe_t    cqe_o,
  output logic                 cqe_valid_o,
  output rdma_sq_pkg::cq_idx_t cq_idx_o
);

  typedef enum logic {TRK_IDLE, TRK_COUNT} trk_state_e;

  trk_state_e             state_q;
  rdma_sq_pkg::cqe_t      cqe_q;
  rdma_sq_pkg::resp_cnt_t exp_q;
  rdma_sq_pkg::resp_cnt_t cnt_q;
  rdma_sq_pkg::resp_cnt_t cnt_d;
  logic                   count_dat_q;
  logic                   resp_hit;
  logic                   load;
  logic                   match;
  logic                   cqe_valid_q;
  rdma_sq_pkg::cq_idx_t   cq_idx_q;

  assign resp_hit = count_dat_q ? rx_dat_valid_i : rx_ack_valid_i;
  assign load     = (state_q == TRK_IDLE) && done_valid_i;

  // nack restarts the count
  always_comb begin
    cnt_d = cnt_q;
    if (rx_nack_valid_i) begin
      cnt_d = '0;
    end else if (resp_hit) begin
      cnt_d = cnt_q + 32'd1;
    end
  end

  // zero expected count completes straight from the hand-over
  assign match = (state_q == TRK_COUNT) ? (cnt_d == exp_q) : (load && done_i.exp_cnt == '0);

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q     <= TRK_IDLE;
      cnt_q       <= '0;
      cqe_valid_q <= 1'b0;
      cq_idx_q    <= '0;
    end else begin
      cqe_valid_q <= match;
      if (match) begin
        cq_idx_q <= cq_idx_q + 32'd1;
      end
      case (state_q)
        TRK_IDLE: begin
          cnt_q <= '0;
          if (load && !match) begin
            state_q <= TRK_COUNT;
          end
        end
        default: begin
          cnt_q <= cnt_d;
          if (match) begin
            state_q <= TRK_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (load) begin
      cqe_q       <= done_i.cqe;
      exp_q       <= done_i.exp_cnt;
      count_dat_q <= done_i.count_dat;
    end
  end

  assign idle_o      = (state_q == TRK_IDLE);
  assign cqe_o       = cqe_q;
  assign cqe_valid_o = cqe_valid_q;
  assign cq_idx_o    = cq_idx_q;

endmodule

// File: segment_engine.sv
`include "rdma_sq_defs.svh"

module segment_engine (
  input  logic                  axis_aclk_i,
  input  logic                  axis_rstn_i,
  input  rdma_sq_pkg::wqe_cmd_t cmd_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_take_o,
  input  logic                  idle_i,
  output rdma_sq_pkg::sq_req_t  req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output rdma_sq_pkg::done_t    done_o,
  output logic                  done_valid_o
);

  typedef enum logic [1:0] {SEG_IDLE, SEG_EMIT, SEG_DONE} seg_state_e;

  seg_state_e             state_q;
  logic                   take;
  logic                   cmd_bad;
  logic                   advance;
  rdma_sq_pkg::len_t      mtu_cmd;
  rdma_sq_pkg::sq_req_t   first_seg;
  rdma_sq_pkg::sq_req_t   next_seg;
  rdma_sq_pkg::resp_cnt_t rd_beats;

  rdma_sq_pkg::sq_req_t   req_q;
  rdma_sq_pkg::wqe_kind_e kind_q;
  rdma_sq_pkg::wr_id_t    wr_id_q;
  rdma_sq_pkg::qpn_t      qpn_q;
  logic [7:0]             status_q;
  rdma_sq_pkg::len_t      mtu_q;
  rdma_sq_pkg::len_t      rem_q;
  rdma_sq_pkg::vaddr_t    lv_q;
  rdma_sq_pkg::vaddr_t    rv_q;
  rdma_sq_pkg::resp_cnt_t exp_q;

  // one write or send segment
  // ONLY or LAST when the rest fits in an mtu
  function automatic rdma_sq_pkg::sq_req_t build_seg(
    input rdma_sq_pkg::wqe_kind_e kind,
    input rdma_sq_pkg::qpn_t      qpn,
    input logic                   first,
    input rdma_sq_pkg::len_t      rem,
    input rdma_sq_pkg::vaddr_t    lv,
    input rdma_sq_pkg::vaddr_t    rv,
    input rdma_sq_pkg::len_t      mtu
  );
    rdma_sq_pkg::sq_req_t r;
    logic                 fits;
    fits     = (rem <= mtu);
    r.qpn    = qpn;
    r.last   = fits;
    r.lvaddr = lv;
    r.rvaddr = (kind == rdma_sq_pkg::KIND_SEND) ? lv : rv;
    r.len    = fits ? rem : mtu;
    if (kind == rdma_sq_pkg::KIND_SEND) begin
      r.opcode = first ? (fits ? rdma_sq_pkg::SEND_ONLY : rdma_sq_pkg::SEND_FIRST)
                       : (fits ? rdma_sq_pkg::SEND_LAST : rdma_sq_pkg::SEND_MIDDLE);
    end else begin
      r.opcode = first ? (fits ? rdma_sq_pkg::WRITE_ONLY : rdma_sq_pkg::WRITE_FIRST)
                       : (fits ? rdma_sq_pkg::WRITE_LAST : rdma_sq_pkg::WRITE_MIDDLE);
    end
    return r;
  endfunction

  assign mtu_cmd   = rdma_sq_pkg::len_t'(1) << cmd_i.mtu_log;
  assign cmd_bad   = (cmd_i.status != 8'(`RDMA_STATUS_OK));
  assign take      = (state_q == SEG_IDLE) && cmd_valid_i && idle_i;
  assign advance   = (state_q == SEG_EMIT) && req_ready_i && !req_q.last;
  assign first_seg = build_seg(cmd_i.kind, cmd_i.qpn, 1'b1, cmd_i.length,
                               cmd_i.lvaddr, cmd_i.rvaddr, mtu_cmd);
  assign next_seg  = build_seg(kind_q, qpn_q, 1'b0, rem_q, lv_q, rv_q, mtu_q);

  // read beats as length over mtu rounded up
  assign rd_beats = (cmd_i.length >> cmd_i.mtu_log) +
                    {31'd0, |(cmd_i.length & (mtu_cmd - 1'b1))};

  //////////////////////////////////////////////////
  // control

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= SEG_IDLE;
    end else begin
      case (state_q)
        SEG_IDLE: begin
          if (take) begin
            state_q <= cmd_bad ? SEG_DONE : SEG_EMIT;
          end
        end
        SEG_EMIT: begin
          if (req_ready_i && req_q.last) begin
            state_q <= SEG_DONE;
          end
        end
        default: state_q <= SEG_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // segment datapath

  always_ff @(posedge axis_aclk_i) begin
    if (take) begin
      kind_q   <= cmd_i.kind;
      wr_id_q  <= cmd_i.wr_id;
      qpn_q    <= cmd_i.qpn;
      status_q <= cmd_i.status;
      mtu_q    <= mtu_cmd;
      rem_q    <= cmd_i.length - mtu_cmd;
      lv_q     <= cmd_i.lvaddr + rdma_sq_pkg::vaddr_t'(mtu_cmd);
      rv_q     <= cmd_i.rvaddr + rdma_sq_pkg::vaddr_t'(mtu_cmd);
      if (cmd_bad) begin
        exp_q <= '0;
      end else if (cmd_i.kind == rdma_sq_pkg::KIND_READ) begin
        req_q.opcode <= rdma_sq_pkg::READ_REQUEST;
        req_q.qpn    <= cmd_i.qpn;
        req_q.last   <= 1'b1;
        req_q.lvaddr <= cmd_i.lvaddr;
        req_q.rvaddr <= cmd_i.rvaddr;
        req_q.len    <= cmd_i.length;
        exp_q        <= rd_beats;
      end else begin
        req_q <= first_seg;
        exp_q <= 32'd1;
      end
    end else if (advance) begin
      req_q <= next_seg;
      rem_q <= rem_q - mtu_q;
      lv_q  <= lv_q + rdma_sq_pkg::vaddr_t'(mtu_q);
      rv_q  <= rv_q + rdma_sq_pkg::vaddr_t'(mtu_q);
      exp_q <= exp_q + 32'd1;
    end
  end

  always_comb begin
    done_o.cqe.status = status_q;
    done_o.cqe.opcode = kind_q;
    done_o.cqe.wr_id  = wr_id_q;
    done_o.exp_cnt    = exp_q;
    done_o.count_dat  = (kind_q == rdma_sq_pkg::KIND_READ);
  end

  assign cmd_take_o   = take;
  assign req_o        = req_q;
  assign req_valid_o  = (state_q == SEG_EMIT);
  assign done_valid_o = (state_q == SEG_DONE);

endmodule

// File: wqe_decoder.sv
`include "rdma_sq_defs.svh"

module wqe_decoder (
  input  logic                   axis_aclk_i,
  input  logic                   axis_rstn_i,
  input  logic                   wqe_valid_i,
  input  rdma_sq_pkg::wqe_word_t wqe_i,
  input  rdma_sq_pkg::qpn_t      qpn_i,
  input  rdma_sq_pkg::vaddr_t    local_vaddr_i,
  input  rdma_sq_pkg::mtu_code_t mtu_code_i,
  output logic                   wqe_ready_o,
  input  logic                   cmd_take_i,
  output rdma_sq_pkg::wqe_cmd_t  cmd_o,
  output logic                   cmd_valid_o
);

  logic [7:0]            opc;
  rdma_sq_pkg::len_t     len;
  logic                  opc_known;
  logic                  wqe_bad;
  logic                  accept;
  rdma_sq_pkg::wqe_cmd_t cmd_d;
  rdma_sq_pkg::wqe_cmd_t cmd_q;
  logic                  cmd_valid_q;

  assign opc    = wqe_i[`RDMA_OPC_LSB +: 8];
  assign len    = wqe_i[`RDMA_LEN_LSB +: $bits(rdma_sq_pkg::len_t)];
  assign accept = wqe_valid_i && !cmd_valid_q;

  always_comb begin
    opc_known = (opc == rdma_sq_pkg::KIND_WRITE) ||
                (opc == rdma_sq_pkg::KIND_SEND)  ||
                (opc == rdma_sq_pkg::KIND_READ);
    wqe_bad   = !opc_known || (len == '0) || (mtu_code_i > `RDMA_MTU_CODE_MAX);

    // raw opcode is kept so a rejected wqe still reports it
    cmd_d.kind    = rdma_sq_pkg::wqe_kind_e'(opc);
    cmd_d.wr_id   = wqe_i[`RDMA_WRID_LSB +: $bits(rdma_sq_pkg::wr_id_t)];
    cmd_d.length  = len;
    cmd_d.lvaddr  = local_vaddr_i;
    cmd_d.rvaddr  = wqe_i[`RDMA_RVADDR_LSB +: $bits(rdma_sq_pkg::vaddr_t)];
    cmd_d.qpn     = qpn_i;
    cmd_d.mtu_log = 4'(`RDMA_MTU_BASE_LOG) + 4'(mtu_code_i);
    cmd_d.status  = wqe_bad ? 8'(`RDMA_STATUS_BAD_WQE) : 8'(`RDMA_STATUS_OK);
  end

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      cmd_valid_q <= 1'b0;
    end else if (accept) begin
      cmd_valid_q <= 1'b1;
    end else if (cmd_take_i) begin
      cmd_valid_q <= 1'b0;
    end
  end

  // held until execute takes it
  always_ff @(posedge axis_aclk_i) begin
    if (accept) begin
      cmd_q <= cmd_d;
    end
  end

  assign wqe_ready_o = !cmd_valid_q;
  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;

endmodule

// File: rdma_sq_pkg.sv
`include "rdma_sq_defs.svh"

package rdma_sq_pkg;

  typedef logic [`RDMA_WQE_W-1:0] wqe_word_t;
  typedef logic [63:0]            vaddr_t;
  typedef logic [31:0]            len_t;
  typedef logic [23:0]            qpn_t;
  typedef logic [15:0]            wr_id_t;
  typedef logic [2:0]             mtu_code_t;
  typedef logic [31:0]            resp_cnt_t;
  typedef logic [31:0]            cq_idx_t;

  // opcode field of the wqe
  typedef enum logic [7:0] {
    KIND_WRITE = 8'h00,
    KIND_SEND  = 8'h02,
    KIND_READ  = 8'h04
  } wqe_kind_e;

  // rc transport opcodes
  typedef enum logic [7:0] {
    SEND_FIRST   = 8'h00,
    SEND_MIDDLE  = 8'h01,
    SEND_LAST    = 8'h02,
    SEND_ONLY    = 8'h04,
    WRITE_FIRST  = 8'h06,
    WRITE_MIDDLE = 8'h07,
    WRITE_LAST   = 8'h08,
    WRITE_ONLY   = 8'h0A,
    READ_REQUEST = 8'h0C
  } rc_opcode_e;

  typedef struct packed {
    wqe_kind_e  kind;
    wr_id_t     wr_id;
    len_t       length;
    vaddr_t     lvaddr;
    vaddr_t     rvaddr;
    qpn_t       qpn;
    logic [3:0] mtu_log;
    logic [7:0] status;
  } wqe_cmd_t;

  typedef struct packed {
    rc_opcode_e opcode;
    qpn_t       qpn;
    logic       last;
    vaddr_t     lvaddr;
    vaddr_t     rvaddr;
    len_t       len;
  } sq_req_t;

  typedef struct packed {
    logic [7:0] status;
    logic [7:0] opcode;
    wr_id_t     wr_id;
  } cqe_t;

  // hand-over from segmentation to response counting
  typedef struct packed {
    cqe_t      cqe;
    resp_cnt_t exp_cnt;
    logic      count_dat;
  } done_t;

endpackage

// File: rdma_sq_defs.svh
`ifndef RDMA_SQ_DEFS_SVH
`define RDMA_SQ_DEFS_SVH

// wqe word layout
`define RDMA_WQE_W        256
`define RDMA_WRID_LSB     0
`define RDMA_LEN_LSB      96
`define RDMA_OPC_LSB      128
`define RDMA_RVADDR_LSB   160

// mtu is 256 << code
// codes above the max are rejected
`define RDMA_MTU_BASE_LOG 8
`define RDMA_MTU_CODE_MAX 4

// completion status
`define RDMA_STATUS_OK      0
`define RDMA_STATUS_BAD_WQE 1

`endif
